/* build.f */
common/isa_pkg.sv
common/pipe_pkg.sv
hw/fetch_unit.sv
hw/register_file.sv
exec_lane/instruction_decoder.sv
exec_lane/lane_alu.sv
exec_lane/exec_lane.sv
hw/dual_issue_core.sv
tests/core_tb.sv

/* common/isa_pkg.sv */
package isa_pkg;

  localparam int DATA_WIDTH    = 32;
  localparam int INST_WIDTH    = 32;
  localparam int ADDR_WIDTH    = 16;
  localparam int REG_ADDR_BITS = 5;
  localparam int IMM_WIDTH     = 16;
  localparam int OPCODE_BITS   = 6;
  localparam int FUNCT_BITS    = 6;

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [INST_WIDTH-1:0]    inst_t;
  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [IMM_WIDTH-1:0]     imm_t;

  // instruction word fields
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int FUNCT_MSB  = 5;
  localparam int FUNCT_LSB  = 0;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  // anything not listed here is a nop
  typedef enum logic [OPCODE_BITS-1:0] {
    R_TYPE = 6'd0,
    ADDI   = 6'd8,
    ANDI   = 6'd12,
    ORI    = 6'd13
  } opcode_e;

  typedef enum logic [FUNCT_BITS-1:0] {
    ADD = 6'd32,
    SUB = 6'd34,
    AND = 6'd36,
    OR  = 6'd37,
    XOR = 6'd38,
    SLT = 6'd42
  } funct_e;

endpackage

/* common/pipe_pkg.sv */
package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // write_en is only set for supported encodings
  typedef struct packed {
    logic               write_en;
    alu_op_e            alu_op;
    logic               use_imm;
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    isa_pkg::reg_addr_t dst;
    isa_pkg::data_t     imm;
  } decoded_op_t;

  // retire entry, also the forwarding source and register write
  typedef struct packed {
    logic               valid;
    isa_pkg::reg_addr_t dst;
    isa_pkg::data_t     data;
  } lane_wb_t;

  typedef struct packed {
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
  } read_req_t;

  typedef struct packed {
    isa_pkg::data_t rs_data;
    isa_pkg::data_t rt_data;
  } read_data_t;

endpackage

/* exec_lane/exec_lane.sv */
module exec_lane #(
  parameter int NUM_LANES = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  isa_pkg::inst_t       inst,
  input  logic                 inst_valid,
  output pipe_pkg::read_req_t  read_req,
  input  pipe_pkg::read_data_t read_data,
  input  pipe_pkg::lane_wb_t   wb_all [NUM_LANES],
  output pipe_pkg::lane_wb_t   wb
);

  pipe_pkg::decoded_op_t dec_op;

  // decode/execute register
  pipe_pkg::decoded_op_t ex_op;
  pipe_pkg::read_data_t  ex_operands;

  isa_pkg::data_t fwd_a;
  isa_pkg::data_t fwd_b;
  isa_pkg::data_t alu_b;
  isa_pkg::data_t alu_result;

  // highest matching lane wins, r0 never forwards
  function automatic isa_pkg::data_t forward_operand(
    input isa_pkg::reg_addr_t src,
    input isa_pkg::data_t     read_value,
    input pipe_pkg::lane_wb_t sources [NUM_LANES]
  );
    isa_pkg::data_t value;
    value = read_value;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (sources[i].valid && sources[i].dst == src && src != '0) begin
        value = sources[i].data;
      end
    end
    return value;
  endfunction

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  instruction_decoder decoder (
    .inst(inst),
    .op(dec_op)
  );

  assign read_req.rs = dec_op.rs;
  assign read_req.rt = dec_op.rt;

  // write_en doubles as the stage valid
  always_ff @(posedge clk) begin
    ex_op       <= dec_op;
    ex_operands <= read_data;
    if (rst) begin
      ex_op.write_en <= 1'b0;
    end else begin
      ex_op.write_en <= inst_valid && dec_op.write_en;
    end
  end

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  assign fwd_a = forward_operand(ex_op.rs, ex_operands.rs_data, wb_all);
  assign fwd_b = forward_operand(ex_op.rt, ex_operands.rt_data, wb_all);
  assign alu_b = ex_op.use_imm ? ex_op.imm : fwd_b;

  lane_alu alu (
    .alu_op(ex_op.alu_op),
    .a(fwd_a),
    .b(alu_b),
    .result(alu_result)
  );

  // execute/write-back register
  always_ff @(posedge clk) begin
    wb.dst  <= ex_op.dst;
    wb.data <= alu_result;
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= ex_op.write_en;
    end
  end

endmodule

/* exec_lane/instruction_decoder.sv */
module instruction_decoder (
  input  isa_pkg::inst_t        inst,
  output pipe_pkg::decoded_op_t op
);

  isa_pkg::opcode_e opcode;
  isa_pkg::funct_e  funct;
  isa_pkg::imm_t    imm;

  assign opcode = isa_pkg::opcode_e'(inst[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);
  assign funct  = isa_pkg::funct_e'(inst[isa_pkg::FUNCT_MSB:isa_pkg::FUNCT_LSB]);
  assign imm    = inst[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];

  always_comb begin
    op.write_en = 1'b0;
    op.alu_op   = pipe_pkg::ALU_ADD;
    op.use_imm  = 1'b0;
    op.rs       = inst[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    op.rt       = inst[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    op.dst      = inst[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    // zero-extended, also for addi
    op.imm      = isa_pkg::data_t'(imm);

    case (opcode)
      isa_pkg::R_TYPE: begin
        op.write_en = 1'b1;
        case (funct)
          isa_pkg::ADD: op.alu_op = pipe_pkg::ALU_ADD;
          isa_pkg::SUB: op.alu_op = pipe_pkg::ALU_SUB;
          isa_pkg::AND: op.alu_op = pipe_pkg::ALU_AND;
          isa_pkg::OR:  op.alu_op = pipe_pkg::ALU_OR;
          isa_pkg::XOR: op.alu_op = pipe_pkg::ALU_XOR;
          isa_pkg::SLT: op.alu_op = pipe_pkg::ALU_SLT;
          default:      op.write_en = 1'b0;
        endcase
      end
      isa_pkg::ADDI, isa_pkg::ANDI, isa_pkg::ORI: begin
        // immediate forms write rt
        op.write_en = 1'b1;
        op.use_imm  = 1'b1;
        op.dst      = inst[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
        if (opcode == isa_pkg::ANDI) begin
          op.alu_op = pipe_pkg::ALU_AND;
        end else if (opcode == isa_pkg::ORI) begin
          op.alu_op = pipe_pkg::ALU_OR;
        end else begin
          op.alu_op = pipe_pkg::ALU_ADD;
        end
      end
      default: begin
        op.write_en = 1'b0;
      end
    endcase
  end

endmodule

/* exec_lane/lane_alu.sv */
module lane_alu (
  input  pipe_pkg::alu_op_e alu_op,
  input  isa_pkg::data_t    a,
  input  isa_pkg::data_t    b,
  output isa_pkg::data_t    result
);

  logic less;

  // signed compare for slt
  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      pipe_pkg::ALU_ADD: begin
        result = a + b;
      end
      pipe_pkg::ALU_SUB: begin
        result = a - b;
      end
      pipe_pkg::ALU_AND: begin
        result = a & b;
      end
      pipe_pkg::ALU_OR: begin
        result = a | b;
      end
      pipe_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      pipe_pkg::ALU_SLT: begin
        result = isa_pkg::data_t'(less);
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* hw/dual_issue_core.sv */
module dual_issue_core #(
  parameter int NUM_LANES = 2
) (
  input  logic               clk,
  input  logic               rst,
  output isa_pkg::addr_t     pc,
  input  isa_pkg::inst_t     bundle [NUM_LANES],
  output pipe_pkg::lane_wb_t wb [NUM_LANES]
);

  isa_pkg::inst_t       lane_inst [NUM_LANES];
  logic                 lane_valid;
  pipe_pkg::read_req_t  read_req [NUM_LANES];
  pipe_pkg::read_data_t read_data [NUM_LANES];

  fetch_unit #(
    .NUM_LANES(NUM_LANES)
  ) fetch (
    .clk(clk),
    .rst(rst),
    .pc(pc),
    .bundle(bundle),
    .lane_inst(lane_inst),
    .lane_valid(lane_valid)
  );

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////

  // every lane sees the full wb array for forwarding
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exec_lane #(
      .NUM_LANES(NUM_LANES)
    ) lane (
      .clk(clk),
      .rst(rst),
      .inst(lane_inst[i]),
      .inst_valid(lane_valid),
      .read_req(read_req[i]),
      .read_data(read_data[i]),
      .wb_all(wb),
      .wb(wb[i])
    );
  end

  register_file #(
    .NUM_LANES(NUM_LANES)
  ) regfile (
    .clk(clk),
    .rst(rst),
    .read_req(read_req),
    .read_data(read_data),
    .wb(wb)
  );

endmodule

/* hw/fetch_unit.sv */
module fetch_unit #(
  parameter int NUM_LANES = 2
) (
  input  logic           clk,
  input  logic           rst,
  output isa_pkg::addr_t pc,
  input  isa_pkg::inst_t bundle [NUM_LANES],
  output isa_pkg::inst_t lane_inst [NUM_LANES],
  output logic           lane_valid
);

  ////////////////////////////////////////
  // program counter
  ////////////////////////////////////////

  // one bundle per cycle, no stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc + isa_pkg::addr_t'(NUM_LANES);
    end
  end

  ////////////////////////////////////////
  // fetch/decode register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= 1'b1;
    end
  end

  // word i of the bundle goes to lane i
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_inst[i] <= bundle[i];
    end
  end

endmodule

/* hw/register_file.sv */
module register_file #(
  parameter int NUM_LANES = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::read_req_t  read_req [NUM_LANES],
  output pipe_pkg::read_data_t read_data [NUM_LANES],
  input  pipe_pkg::lane_wb_t   wb [NUM_LANES]
);

  localparam int NUM_REGS = 2 ** isa_pkg::REG_ADDR_BITS;

  isa_pkg::data_t regs [NUM_REGS];

  // write-through read, later lane wins
  function automatic isa_pkg::data_t bypass_read(
    input isa_pkg::reg_addr_t addr,
    input isa_pkg::data_t     stored,
    input pipe_pkg::lane_wb_t writes [NUM_LANES]
  );
    isa_pkg::data_t value;
    value = stored;
    for (int w = 0; w < NUM_LANES; w++) begin
      if (writes[w].valid && writes[w].dst == addr) begin
        value = writes[w].data;
      end
    end
    // r0 is hardwired
    if (addr == '0) begin
      value = '0;
    end
    return value;
  endfunction

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      read_data[l].rs_data = bypass_read(read_req[l].rs, regs[read_req[l].rs], wb);
      read_data[l].rt_data = bypass_read(read_req[l].rt, regs[read_req[l].rt], wb);
    end
  end

  ////////////////////////////////////////
  // write ports
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_LANES; w++) begin
        if (wb[w].valid && wb[w].dst != '0) begin
          regs[wb[w].dst] <= wb[w].data;
        end
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module core_tb -f build.f -o core_tb || exit 1
out=$(./obj_dir/core_tb)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

/* tests/core_tb.sv */
module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_LANES  = 2;
  localparam int PROG_WORDS = 256;
  localparam int TAIL_WORDS = 2 * NUM_LANES;
  localparam int LATENCY    = 3;
  localparam int NUM_TESTS  = 6;
  localparam int MAX_CYCLES = PROG_WORDS + 20;

  typedef struct packed {
    int                                 due;
    int                                 tag;
    pipe_pkg::lane_wb_t [NUM_LANES-1:0] lanes;
  } expect_t;

  logic               clk;
  logic               rst;
  isa_pkg::addr_t     pc;
  isa_pkg::inst_t     bundle [NUM_LANES];
  pipe_pkg::lane_wb_t wb [NUM_LANES];

  isa_pkg::inst_t prog [PROG_WORDS];
  isa_pkg::data_t model_regs [32];
  isa_pkg::data_t snap [32];
  expect_t        pending [$];
  int             test_errors [NUM_TESTS];
  int             test_retires [NUM_TESTS];
  int             seed;
  int             edge_count;
  int             fetch_addr;
  int             cur_test;
  int             cycle_count = 0;

  dual_issue_core #(
    .NUM_LANES(NUM_LANES)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .pc(pc),
    .bundle(bundle),
    .wb(wb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // program generation
  ////////////////////////////////////////

  function automatic int rand_range(input int lo, input int hi);
    int value;
    value = $random(seed);
    return lo + int'($unsigned(value) % $unsigned(hi - lo + 1));
  endfunction

  function automatic logic [15:0] rand_imm();
    return 16'($random(seed));
  endfunction

  function automatic logic [5:0] random_funct();
    case (rand_range(0, 5))
      0: return isa_pkg::ADD;
      1: return isa_pkg::SUB;
      2: return isa_pkg::AND;
      3: return isa_pkg::OR;
      4: return isa_pkg::XOR;
      default: return isa_pkg::SLT;
    endcase
  endfunction

  function automatic logic [5:0] random_imm_op();
    case (rand_range(0, 2))
      0: return isa_pkg::ADDI;
      1: return isa_pkg::ANDI;
      default: return isa_pkg::ORI;
    endcase
  endfunction

  function automatic isa_pkg::inst_t r_inst(input logic [5:0] funct, input int rs,
                                            input int rt, input int rd);
    return {6'd0, isa_pkg::reg_addr_t'(rs), isa_pkg::reg_addr_t'(rt),
            isa_pkg::reg_addr_t'(rd), 5'd0, funct};
  endfunction

  function automatic isa_pkg::inst_t i_inst(input logic [5:0] opcode, input int rs,
                                            input int rt, input logic [15:0] imm);
    return {opcode, isa_pkg::reg_addr_t'(rs), isa_pkg::reg_addr_t'(rt), imm};
  endfunction

  task automatic build_program();
    int shared;
    int d;
    logic [5:0] code;
    logic [15:0] imm;
    shared = 5;
    // first words seed registers for the r-type mix
    for (int a = 0; a < 64; a++) begin
      if (a < 16) begin
        prog[a] = i_inst(isa_pkg::ORI, 0, rand_range(1, 31), rand_imm());
      end else begin
        prog[a] = r_inst(random_funct(), rand_range(0, 31), rand_range(0, 31),
                         rand_range(0, 31));
      end
    end
    for (int a = 64; a < 112; a++) begin
      imm = rand_imm();
      if (a % 2 == 0) begin
        imm[15] = 1'b1;
      end
      prog[a] = i_inst(random_imm_op(), rand_range(0, 31), rand_range(0, 31), imm);
    end
    // tight register set for forwarding
    for (int a = 112; a < 176; a++) begin
      if (rand_range(0, 2) == 0) begin
        prog[a] = i_inst(random_imm_op(), rand_range(1, 4), rand_range(1, 4), rand_imm());
      end else begin
        prog[a] = r_inst(random_funct(), rand_range(1, 4), rand_range(1, 4), rand_range(1, 4));
      end
    end
    for (int a = 176; a < 208; a += 2) begin
      d = rand_range(5, 9);
      if (((a - 176) / 2) % 2 == 0) begin
        // lane 1 reads lane 0's destination
        prog[a]     = r_inst(random_funct(), shared, rand_range(1, 31), d);
        prog[a + 1] = r_inst(random_funct(), d, rand_range(1, 31), rand_range(10, 14));
      end else begin
        prog[a]     = i_inst(isa_pkg::ORI, rand_range(1, 31), d, rand_imm());
        prog[a + 1] = i_inst(isa_pkg::ADDI, rand_range(1, 31), d, rand_imm());
        shared      = d;
      end
    end
    for (int a = 208; a < PROG_WORDS; a++) begin
      case (rand_range(0, 5))
        0: prog[a] = r_inst(random_funct(), rand_range(1, 31), rand_range(1, 31), 0);
        1: prog[a] = i_inst(random_imm_op(), rand_range(1, 31), 0, rand_imm());
        2: prog[a] = r_inst(random_funct(), 0, rand_range(0, 31), rand_range(1, 31));
        3: prog[a] = '0;
        4: begin
          code = 6'(rand_range(1, 63));
          if (code == isa_pkg::ADDI || code == isa_pkg::ANDI || code == isa_pkg::ORI) begin
            code = 6'd63;
          end
          prog[a] = {code, 26'($random(seed))};
        end
        default: begin
          // function codes below 32 are all unknown
          code    = 6'(rand_range(0, 31));
          prog[a] = r_inst(code, rand_range(1, 31), rand_range(1, 31), rand_range(1, 31));
        end
      endcase
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic isa_pkg::inst_t fetch_word(input int addr);
    if (addr < PROG_WORDS) return prog[addr];
    return '0;
  endfunction

  function automatic int tag_of(input int addr);
    if (addr < 64) return 1;
    if (addr < 112) return 2;
    if (addr < 176) return 3;
    if (addr < 208) return 4;
    return 5;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0: return "reset";
      1: return "r-type random";
      2: return "immediate zero-extend";
      3: return "forwarding";
      4: return "same bundle";
      default: return "r0 and nops";
    endcase
  endfunction

  // operands come from snap, the state before the bundle
  function automatic pipe_pkg::lane_wb_t expected_retire(input isa_pkg::inst_t word);
    pipe_pkg::lane_wb_t e;
    isa_pkg::data_t a;
    isa_pkg::data_t b;
    isa_pkg::data_t imm;
    a   = snap[word[25:21]];
    b   = snap[word[20:16]];
    imm = {16'd0, word[15:0]};
    e   = '0;
    case (word[31:26])
      isa_pkg::R_TYPE: begin
        e.valid = 1'b1;
        e.dst   = word[15:11];
        case (word[5:0])
          isa_pkg::ADD: e.data = a + b;
          isa_pkg::SUB: e.data = a - b;
          isa_pkg::AND: e.data = a & b;
          isa_pkg::OR:  e.data = a | b;
          isa_pkg::XOR: e.data = a ^ b;
          isa_pkg::SLT: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: e.valid = 1'b0;
        endcase
      end
      isa_pkg::ADDI: begin
        e.valid = 1'b1;
        e.dst   = word[20:16];
        e.data  = a + imm;
      end
      isa_pkg::ANDI: begin
        e.valid = 1'b1;
        e.dst   = word[20:16];
        e.data  = a & imm;
      end
      isa_pkg::ORI: begin
        e.valid = 1'b1;
        e.dst   = word[20:16];
        e.data  = a | imm;
      end
      default: e.valid = 1'b0;
    endcase
    return e;
  endfunction

  task automatic capture_bundle(input logic in_reset);
    expect_t e;
    e     = '0;
    e.due = edge_count + LATENCY;
    e.tag = in_reset ? 0 : tag_of(fetch_addr);
    if (!in_reset) begin
      snap = model_regs;
      for (int i = 0; i < NUM_LANES; i++) begin
        e.lanes[i] = expected_retire(fetch_word(fetch_addr + i));
      end
      // later lane wins
      for (int i = 0; i < NUM_LANES; i++) begin
        if (e.lanes[i].valid && e.lanes[i].dst != '0) begin
          model_regs[e.lanes[i].dst] = e.lanes[i].data;
        end
      end
    end
    pending.push_back(e);
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic compare_lane(input int lane, input pipe_pkg::lane_wb_t exp, input int tag);
    assert (wb[lane].valid === exp.valid) else begin
      $display("Mismatch at %0t: wb[%0d].valid is %b, expected %b",
               $time, lane, wb[lane].valid, exp.valid);
      test_errors[tag]++;
    end
    if (exp.valid && wb[lane].valid) begin
      test_retires[tag]++;
      assert (wb[lane].dst === exp.dst) else begin
        $display("Mismatch at %0t: wb[%0d].dst is %0d, expected %0d",
                 $time, lane, wb[lane].dst, exp.dst);
        test_errors[tag]++;
      end
      assert (wb[lane].data === exp.data) else begin
        $display("Mismatch at %0t: wb[%0d].data is %h, expected %h",
                 $time, lane, wb[lane].data, exp.data);
        test_errors[tag]++;
      end
    end
  endtask

  task automatic report_test(input int t);
    if (test_errors[t] == 0) begin
      $display("test %0d (%s): ok, %0d retires checked", t, test_name(t), test_retires[t]);
    end else begin
      $display("test %0d (%s): %0d errors, %0d retires checked",
               t, test_name(t), test_errors[t], test_retires[t]);
    end
  endtask

  task automatic check_retires();
    expect_t e;
    while (pending.size() > 0 && pending[0].due == edge_count) begin
      e = pending.pop_front();
      if (e.tag != cur_test) begin
        report_test(cur_test);
        cur_test = e.tag;
      end
      for (int i = 0; i < NUM_LANES; i++) begin
        compare_lane(i, e.lanes[i], e.tag);
      end
    end
  endtask

  initial begin
    logic in_reset;
    int next_addr;
    int total;
    int failed;
    rst <= 1'b1;
    for (int i = 0; i < NUM_LANES; i++) begin
      bundle[i] <= '0;
    end
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errors[t]  = 0;
      test_retires[t] = 0;
    end
    seed       = 32'he574;
    edge_count = 0;
    fetch_addr = 0;
    cur_test   = 0;
    build_program();

    while (fetch_addr < PROG_WORDS + TAIL_WORDS || pending.size() > 0) begin
      @(posedge clk);
      in_reset = rst;
      if (edge_count > 0) begin
        assert (pc === isa_pkg::addr_t'(fetch_addr)) else begin
          $display("Mismatch at %0t: pc is %0d, expected %0d", $time, pc, fetch_addr);
          test_errors[cur_test]++;
        end
      end
      check_retires();
      if (in_reset || fetch_addr < PROG_WORDS + TAIL_WORDS) begin
        capture_bundle(in_reset);
      end
      // instruction memory answers for the pc of the next cycle
      next_addr = in_reset ? 0 : fetch_addr + NUM_LANES;
      for (int i = 0; i < NUM_LANES; i++) begin
        bundle[i] <= fetch_word(next_addr + i);
      end
      fetch_addr = next_addr;
      if (edge_count == 1) begin
        rst <= 1'b0;
      end
      edge_count++;
    end

    report_test(cur_test);
    total  = 0;
    failed = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += test_errors[t];
      if (test_errors[t] != 0) begin
        failed++;
      end
    end
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed, total);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
